// ==== logic/tcb_mem_pkg.sv ====
/*
 * tcb memory package
 * bus widths and the request, response and tag structs shared by the
 * banked data memory, its decoder and its response mux
 */

package tcb_mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////////////////////////

    // byte address
    localparam int unsigned tcb_adr_w = 32;
    // data word
    localparam int unsigned tcb_dat_w = 32;
    // byte lanes per word
    localparam int unsigned tcb_byt_n = tcb_dat_w / 8;

    // upper bound on the bank count, sizes the tag bank field
    localparam int unsigned tcb_max_banks = 16;

    //////////////////////////////////////////////////////////////////////
    // bus structs
    //////////////////////////////////////////////////////////////////////

    // request, qualified by a separate valid
    typedef struct packed {
        logic                 wen;
        logic [tcb_adr_w-1:0] adr;
        logic [tcb_byt_n-1:0] byt;
        logic [tcb_dat_w-1:0] wdt;
    } tcb_req_t;

    // response, one cycle after the request
    typedef struct packed {
        logic [tcb_dat_w-1:0] rdt;
        logic                 err;
    } tcb_rsp_t;

    // request summary held by the decoder for one cycle
    typedef struct packed {
        logic                               vld;
        logic                               wen;
        logic                               err;
        logic [$clog2(tcb_max_banks)-1:0]   bank;
        logic [tcb_byt_n-1:0]               byt;
    } tcb_tag_t;

endpackage : tcb_mem_pkg

// ==== logic/tcb_mem_decoder.sv ====
/*
 * tcb memory decoder
 * range check and word interleaved bank select for each request,
 * plus the tag register that steers the response one cycle later
 */

`timescale 1ns/1ps

module tcb_mem_decoder #(
    parameter int unsigned BANKS      = 4,
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                  sub,
    input  logic                  rst_n,
    input  logic                  req_vld,
    input  tcb_mem_pkg::tcb_req_t req,
    output logic [BANKS-1:0]      bank_sel,
    output tcb_mem_pkg::tcb_req_t bank_req,
    output tcb_mem_pkg::tcb_tag_t tag
);

    import tcb_mem_pkg::*;

    // width of the tag bank field
    localparam int unsigned BNK_W     = $clog2(tcb_max_banks);
    // total words over all banks
    localparam int unsigned MEM_WORDS = BANKS * BANK_WORDS;

    logic [tcb_adr_w-3:0] word_adr;
    logic                 in_range;
    logic [BNK_W-1:0]     bank_idx;

    //////////////////////////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////////////////////////

    // drop the byte offset
    assign word_adr = req.adr[tcb_adr_w-1:2];
    // anything above the last row of the last bank is out of range
    assign in_range = (word_adr < MEM_WORDS);
    // low word bits pick the bank, both powers of two
    assign bank_idx = BNK_W'(word_adr % BANKS);

    // shared request to all banks, row in the low address bits
    always_comb begin
        bank_req     = req;
        bank_req.adr = tcb_adr_w'((word_adr / BANKS) % BANK_WORDS);
    end

    // one select per bank, none when out of range
    always_comb begin
        for (int unsigned b = 0; b < BANKS; b++) begin
            bank_sel[b] = req_vld && in_range && (bank_idx == BNK_W'(b));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response tag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (!rst_n) begin
            tag <= '0;
        end else begin
            tag.vld  <= req_vld;
            tag.wen  <= req.wen;
            tag.err  <= !in_range;
            tag.bank <= bank_idx;
            tag.byt  <= req.byt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    initial begin
        assert (BANKS <= tcb_max_banks && (BANKS & (BANKS - 1)) == 0)
            else $fatal(1, "bank count must be a power of two up to %0d", tcb_max_banks);
    end

    // only one bank may answer a request
    a_sel_onehot : assert property (@(posedge sub) disable iff (!rst_n) $onehot0(bank_sel));

endmodule : tcb_mem_decoder

// ==== logic/tcb_mem_bank.sv ====
/*
 * tcb memory bank
 * single port word wide storage with byte lane writes and a
 * registered read port that loads only the enabled lanes
 */

`timescale 1ns/1ps

module tcb_mem_bank #(
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                               sub,
    input  logic                               sel,
    input  tcb_mem_pkg::tcb_req_t              req,
    output logic [tcb_mem_pkg::tcb_dat_w-1:0]  rdt
);

    import tcb_mem_pkg::*;

    // row index width, at least one bit
    localparam int unsigned ROW_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    logic [tcb_dat_w-1:0] mem [0:BANK_WORDS-1];
    logic [ROW_W-1:0]     row;

    //////////////////////////////////////////////////////////////////////
    // row select
    //////////////////////////////////////////////////////////////////////

    // decoder already moved the row down to bit 0
    assign row = req.adr[ROW_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // write side, byte lane merge into the stored word
    always_ff @(posedge sub) begin
        if (sel && req.wen) begin
            for (int unsigned b = 0; b < tcb_byt_n; b++) begin
                if (req.byt[b]) begin
                    mem[row][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    // read side
    // lanes left disabled hold their previous value
    always_ff @(posedge sub) begin
        if (sel && !req.wen) begin
            for (int unsigned b = 0; b < tcb_byt_n; b++) begin
                if (req.byt[b]) begin
                    rdt[8*b +: 8] <= mem[row][8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a selected access must know whether and which lanes to touch
    a_sel_known : assert property (
        @(posedge sub) sel |-> !$isunknown({req.wen, req.byt})
    );

endmodule : tcb_mem_bank

// ==== logic/tcb_rsp_mux.sv ====
/*
 * tcb response mux
 * picks the tagged bank's read word, clears lanes that were not
 * requested and forms the response with valid and error
 */

`timescale 1ns/1ps

module tcb_rsp_mux #(
    parameter int unsigned BANKS = 4
) (
    input  tcb_mem_pkg::tcb_tag_t              tag,
    input  logic [tcb_mem_pkg::tcb_dat_w-1:0]  bank_rdt [BANKS],
    output logic                               rsp_vld,
    output tcb_mem_pkg::tcb_rsp_t              rsp
);

    import tcb_mem_pkg::*;

    localparam int unsigned BNK_W = $clog2(tcb_max_banks);

    logic [tcb_dat_w-1:0] sel_rdt;
    logic                 rd_ok;

    //////////////////////////////////////////////////////////////////////
    // bank select
    //////////////////////////////////////////////////////////////////////

    // index only within BANKS, anything else reads as zero
    always_comb begin
        sel_rdt = '0;
        for (int unsigned b = 0; b < BANKS; b++) begin
            if (tag.bank == BNK_W'(b)) begin
                sel_rdt = bank_rdt[b];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // data only for a good read
    assign rd_ok = !tag.wen && !tag.err;

    // stale read register lanes must not leak out
    always_comb begin
        for (int unsigned b = 0; b < tcb_byt_n; b++) begin
            rsp.rdt[8*b +: 8] = (rd_ok && tag.byt[b]) ? sel_rdt[8*b +: 8] : 8'h00;
        end
    end

    assign rsp.err = tag.err;
    assign rsp_vld = tag.vld;

    // decoder never tags a write beyond the banks of this mux
    always_comb begin
        if (tag.vld && tag.err) begin
            a_err_bank : assert (!(tag.wen && tag.bank >= BNK_W'(BANKS)));
        end
    end

endmodule : tcb_rsp_mux

// ==== logic/tcb_mem_top.sv ====
/*
 * tcb banked data memory
 * word interleaved single port banks behind one request port,
 * response with one cycle of latency
 */

`timescale 1ns/1ps

module tcb_mem_top #(
    parameter int unsigned BANKS      = 4,
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                  sub,
    input  logic                  rst_n,
    input  logic                  req_vld,
    input  tcb_mem_pkg::tcb_req_t req,
    output logic                  rsp_vld,
    output tcb_mem_pkg::tcb_rsp_t rsp
);

    import tcb_mem_pkg::*;

    logic [BANKS-1:0]     bank_sel;
    tcb_req_t             bank_req;
    tcb_tag_t             tag;
    logic [tcb_dat_w-1:0] bank_rdt [BANKS];

    //////////////////////////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////////////////////////

    tcb_mem_decoder #(
        .BANKS      (BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_decoder (
        .sub      (sub),
        .rst_n    (rst_n),
        .req_vld  (req_vld),
        .req      (req),
        .bank_sel (bank_sel),
        .bank_req (bank_req),
        .tag      (tag)
    );

    // banks share the request, only the select differs
    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        tcb_mem_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .sub (sub),
            .sel (bank_sel[b]),
            .req (bank_req),
            .rdt (bank_rdt[b])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    tcb_rsp_mux #(
        .BANKS (BANKS)
    ) u_rsp_mux (
        .tag      (tag),
        .bank_rdt (bank_rdt),
        .rsp_vld  (rsp_vld),
        .rsp      (rsp)
    );

endmodule : tcb_mem_top

// ==== verification/tcb_mem_tests.svh ====
/*
 * tcb memory directed tests
 * request and check helpers plus the test tasks, included in the tb
 */

//////////////////////////////////////////////////////////////////////
// helpers
//////////////////////////////////////////////////////////////////////

task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
        else report_error($sformatf("[FAIL] %s expected %h got %h", name, exp, act));
endtask

// response of the request taken on the edge just passed
task automatic check_response();
    check_value("rsp_vld", 32'(exp_vld), 32'(rsp_vld));
    if (exp_vld) begin
        check_value("rsp.err", 32'(exp_err), 32'(rsp.err));
        check_value("rsp.rdt", exp_rdt, rsp.rdt);
    end
endtask

// check 1 ns after the edge, leave 2 ns after it for the next drive
task automatic next_cycle();
    @(posedge sub);
    #1;
    check_response();
    #1;
endtask

task automatic idle_cycle();
    req_vld = 1'b0;
    req     = '0;
    exp_vld = 1'b0;
    next_cycle();
endtask

// drive one request, predict its response, update the shadow
task automatic issue_request(input logic wen, input logic [tcb_adr_w-1:0] adr,
                             input logic [tcb_byt_n-1:0] byt,
                             input logic [tcb_dat_w-1:0] wdt);
    int   word;
    logic in_range;
    word     = int'(adr[ADR_TOP-1:2]);
    in_range = (adr[tcb_adr_w-1:ADR_TOP] == '0);
    req_vld  = 1'b1;
    req.wen  = wen;
    req.adr  = adr;
    req.byt  = byt;
    req.wdt  = wdt;
    exp_vld  = 1'b1;
    exp_err  = !in_range;
    exp_rdt  = '0;
    for (int b = 0; b < tcb_byt_n; b++) begin
        if (in_range && byt[b] && !wen) begin
            assert (shadow_known[word][b])
                else report_error("testbench read a byte lane that was never written");
            exp_rdt[8*b +: 8] = shadow_mem[word][8*b +: 8];
        end
        if (in_range && byt[b] && wen) begin
            shadow_mem[word][8*b +: 8] = wdt[8*b +: 8];
            shadow_known[word][b]      = 1'b1;
        end
    end
    next_cycle();
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

// no response while in reset and just after it
task automatic check_reset_quiet();
    rst_n = 1'b0;
    repeat (5) idle_cycle();
    rst_n = 1'b1;
    repeat (4) idle_cycle();
endtask

// full word to one row in each bank, then read back
task automatic word_rw_all_banks();
    logic [tcb_adr_w-1:0] adr;
    for (int b = 0; b < BANKS; b++) begin
        adr = tcb_adr_w'(((8 * b + 3) * BANKS + b) * 4);
        issue_request(1'b1, adr, 4'hf, $urandom);
    end
    for (int b = 0; b < BANKS; b++) begin
        adr = tcb_adr_w'(((8 * b + 3) * BANKS + b) * 4);
        issue_request(1'b0, adr, 4'hf, '0);
    end
    // write then read of the same word in consecutive cycles
    for (int b = 0; b < BANKS; b++) begin
        adr = tcb_adr_w'((40 * BANKS + b) * 4);
        issue_request(1'b1, adr, 4'hf, $urandom);
        issue_request(1'b0, adr, 4'hf, '0);
    end
endtask

// byte and half word merges, partial read enables
task automatic merge_byte_lanes();
    issue_request(1'b1, 32'h0000_0200, 4'hf, 32'h1122_3344);
    issue_request(1'b1, 32'h0000_0200, 4'b0010, 32'h0000_aa00);
    issue_request(1'b1, 32'h0000_0200, 4'b1100, 32'hbeef_0000);
    // other lanes of wdt carry junk
    issue_request(1'b1, 32'h0000_0200, 4'b0001, 32'hdead_bec3);
    issue_request(1'b0, 32'h0000_0200, 4'hf, '0);
    issue_request(1'b0, 32'h0000_0200, 4'b0101, '0);
    issue_request(1'b0, 32'h0000_0200, 4'b1000, '0);
    issue_request(1'b0, 32'h0000_0200, 4'b0000, '0);
    // same again in the last bank
    issue_request(1'b1, 32'h0000_03ac, 4'hf, 32'h0102_0304);
    issue_request(1'b1, 32'h0000_03ac, 4'b0011, 32'h5555_7788);
    issue_request(1'b0, 32'h0000_03ac, 4'b0110, '0);
    issue_request(1'b0, 32'h0000_03ac, 4'hf, '0);
endtask

// one random request per cycle
task automatic random_back_to_back();
    int                   word;
    logic                 wen;
    logic [tcb_byt_n-1:0] byt;
    repeat (200) begin
        // small window so reads hit written words, all banks covered
        word = int'($urandom % 64);
        wen  = 1'($urandom % 2);
        byt  = tcb_byt_n'($urandom % 16);
        if (!wen) begin
            byt = byt & shadow_known[word];
        end
        issue_request(wen, tcb_adr_w'(word * 4) | tcb_adr_w'($urandom % 4), byt, $urandom);
    end
    idle_cycle();
endtask

// err with zero data above the memory, aliased word untouched
task automatic reject_out_of_range();
    issue_request(1'b1, 32'h0000_00a4, 4'hf, 32'h5a5a_c3c3);
    issue_request(1'b1, 32'h0000_10a4, 4'hf, 32'hffff_ffff);
    issue_request(1'b0, 32'h0000_20a4, 4'hf, '0);
    issue_request(1'b1, 32'h8000_00a4, 4'hf, 32'h0000_0000);
    issue_request(1'b0, 32'h0000_1000, 4'hf, '0);
    issue_request(1'b0, 32'hffff_fffc, 4'hf, '0);
    issue_request(1'b0, 32'h0000_00a4, 4'hf, '0);
endtask

// ==== verification/tcb_mem_tb.sv ====
/*
 * tcb memory testbench
 * drives the banked data memory through directed tests and checks
 * every response against a byte lane shadow model
 */

`timescale 1ns/1ps

module tcb_mem_tb;

    import tcb_mem_pkg::*;

    localparam int unsigned BANKS      = 4;
    localparam int unsigned BANK_WORDS = 256;
    localparam int unsigned MEM_WORDS  = BANKS * BANK_WORDS;
    // first byte address bit above the memory
    localparam int unsigned ADR_TOP    = $clog2(MEM_WORDS) + 2;
    // tests run a few hundred cycles, wide margin on top
    localparam int unsigned MAX_CYCLES = 2000;
    localparam int unsigned SEED       = 93422;

    logic     sub;
    logic     rst_n;
    logic     req_vld;
    tcb_req_t req;
    logic     rsp_vld;
    tcb_rsp_t rsp;

    // shadow memory, with a written flag per byte lane
    logic [tcb_dat_w-1:0] shadow_mem   [MEM_WORDS];
    logic [tcb_byt_n-1:0] shadow_known [MEM_WORDS];

    // expected response for the request taken on the next edge
    logic                 exp_vld;
    logic                 exp_err;
    logic [tcb_dat_w-1:0] exp_rdt;

    int unsigned cycle_cnt;

    tcb_mem_top #(
        .BANKS      (BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) DUT (
        .sub     (sub),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    // 20 ns clock
    always #10 sub = !sub;

    // run limit
    always @(posedge sub) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_error("timeout, the tests did not finish within the cycle limit");
        end
    end

    `include "tcb_mem_tests.svh"

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        sub       = 1'b0;
        rst_n     = 1'b0;
        req_vld   = 1'b0;
        req       = '0;
        exp_vld   = 1'b0;
        exp_err   = 1'b0;
        exp_rdt   = '0;
        cycle_cnt = 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            shadow_mem[w]   = '0;
            shadow_known[w] = '0;
        end
        void'($urandom(SEED));

        check_reset_quiet();
        word_rw_all_banks();
        merge_byte_lanes();
        random_back_to_back();
        reject_out_of_range();

        idle_cycle();
        $display("Verification passed");
        $finish;
    end

endmodule : tcb_mem_tb

// ==== build.f ====
+incdir+verification
logic/tcb_mem_pkg.sv
logic/tcb_mem_decoder.sv
logic/tcb_mem_bank.sv
logic/tcb_rsp_mux.sv
logic/tcb_mem_top.sv
verification/tcb_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the banked memory testbench with verilator and run it
# result is taken from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tcb_mem_tb -o tcb_mem_sim \
    && ./obj_dir/tcb_mem_sim > sim.log 2>&1 \
    || echo "build or simulation exited with an error"

cat sim.log 2>/dev/null

grep -q "Verification passed" sim.log 2>/dev/null \
    && exit 0 \
    || exit 1
